//--- Makefile
TOP = udp_rx_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out=$$(./obj_dir/$(TOP)); echo "$$out"; echo "$$out" | grep -q -F '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

//--- src.f
verilog/udp_rx_pkg.sv
verilog/sync_fifo.sv
verilog/rx_input_align.sv
verilog/rx_header_filter.sv
verilog/rx_frame_writer.sv
verilog/udp_rx_top.sv
test/udp_rx_tb.sv

//--- test/udp_rx_tb.sv
`timescale 1ns/1ps

module udp_rx_tb;
  import udp_rx_pkg::*;

  localparam mac_addr_t LOCAL_MAC   = 48'h02_11_22_33_44_55;
  localparam mac_addr_t SRC_MAC     = 48'h02_AA_BB_CC_DD_EE;
  localparam mac_addr_t MC_MAC      = 48'h01_00_5E_01_02_07;
  localparam ip_addr_t  LOCAL_IP    = 32'h0A_00_00_05;
  localparam ip_addr_t  SRC_IP_BASE = 32'hC0_A8_01_00;
  localparam ip_addr_t  MC_IP       = 32'hEF_01_02_00;
  localparam ip_addr_t  MC_MASK     = 32'hFF_FF_FF_00;
  localparam udp_port_t LOCAL_PORT  = 16'd5000;
  localparam int        SEED        = 64925;
  localparam int        WAIT_LIMIT  = 2000;
  localparam int        QUIET       = 24;

  // one frame of the table; pay_words is the payload length N-5
  typedef struct packed {
    mac_addr_t   dst_mac;
    logic [15:0] ethertype;
    logic [7:0]  ver_ihl;
    logic [7:0]  proto;
    ip_addr_t    dst_ip;
    udp_port_t   dst_port;
    int          pay_words;
    logic        bad;
    logic        enable;
    logic        accept;
    logic        stall;
  } entry_t;

  logic      mac_clk = 1'b0;
  logic      mac_rst;
  logic      local_enable;
  mac_addr_t local_mac;
  ip_addr_t  local_ip;
  udp_port_t local_port;
  ip_addr_t  local_mc_ip;
  ip_addr_t  local_mc_mask;
  word_t     mac_rx_data;
  lanes_t    mac_rx_data_valid;
  logic      mac_rx_good_frame;
  logic      mac_rx_bad_frame;
  logic      rx_valid;
  word_t     rx_data;
  logic      rx_last;
  logic      rx_bad;
  logic      rx_overrun;
  ip_addr_t  rx_source_ip;
  udp_port_t rx_source_port;
  logic      rx_ready;

  entry_t      table_q[$];
  logic [7:0]  frame_bytes[$];
  logic [31:0] lcg_state;
  logic        hold_ready = 1'b0;
  ip_addr_t    exp_src_ip;
  udp_port_t   exp_src_port;

  // words seen leaving the DUT
  word_t     got_data[$];
  logic      got_last[$];
  logic      got_bad[$];
  logic      got_over[$];
  ip_addr_t  got_ip[$];
  udp_port_t got_port[$];

  udp_rx_top i_udp_rx_top (.*);

  always #4 mac_clk = ~mac_clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_word(input word_t got, input word_t exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_flags(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      abort_run($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
    end
  endtask

  task automatic check_source(input ip_addr_t got_ip_v, input udp_port_t got_port_v,
                              input string what);
    if (got_ip_v !== exp_src_ip || got_port_v !== exp_src_port) begin
      abort_run($sformatf("FAILED at %0t: %s is %h:%h, expected %h:%h", $time, what,
                          got_ip_v, got_port_v, exp_src_ip, exp_src_port));
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      abort_run($sformatf("FAILED at %0t: %s is %0d, expected %0d", $time, what, got, exp));
    end
  endtask

  // appends count bytes of value, most significant first
  task automatic push_bytes(input logic [47:0] value, input int count);
    logic [47:0] v;
    v = value << (8 * (6 - count));
    for (int b = 0; b < count; b++) begin
      frame_bytes.push_back(v[47:40]);
      v = v << 8;
    end
  endtask

  task automatic build_frame(input entry_t e, input int idx);
    int n_bytes;
    n_bytes      = (e.pay_words + 5) * 8;
    exp_src_ip   = SRC_IP_BASE + 32'(idx);
    exp_src_port = 16'h4000 + 16'(idx);
    frame_bytes.delete();
    push_bytes(e.dst_mac, 6);
    push_bytes(SRC_MAC, 6);
    push_bytes(48'(e.ethertype), 2);
    push_bytes(48'(e.ver_ihl), 1);
    push_bytes(48'h0, 1);
    push_bytes(48'(n_bytes - 14), 2);
    // id, flags and fragment offset
    push_bytes(48'h0, 4);
    push_bytes(48'h40, 1);
    push_bytes(48'(e.proto), 1);
    push_bytes(48'h0, 2);
    push_bytes(48'(exp_src_ip), 4);
    push_bytes(48'(e.dst_ip), 4);
    push_bytes(48'(exp_src_port), 2);
    push_bytes(48'(e.dst_port), 2);
    push_bytes(48'(n_bytes - 34), 2);
    push_bytes(48'h0, 2);
    while (frame_bytes.size() < n_bytes) begin
      lcg_state = lcg_next(lcg_state);
      frame_bytes.push_back(lcg_state[23:16]);
    end
  endtask

  // payload word k is frame bytes 42+8k..49+8k, first byte on top
  function automatic word_t expected_word(input int k);
    word_t w;
    int    idx;
    w = '0;
    for (int j = 0; j < 8; j++) begin
      idx = 42 + 8 * k + j;
      w   = w << 8;
      if (idx < frame_bytes.size()) begin
        w[7:0] = frame_bytes[idx];
      end
    end
    return w;
  endfunction

  task automatic send_frame(input logic bad);
    word_t data;
    int    n_words;
    n_words = frame_bytes.size() / 8;
    for (int w = 0; w < n_words; w++) begin
      data = '0;
      for (int j = 7; j >= 0; j--) begin
        data = {data[55:0], frame_bytes[8 * w + j]};
      end
      @(posedge mac_clk);
      #1;
      mac_rx_data       = data;
      mac_rx_data_valid = '1;
      mac_rx_good_frame = (w == n_words - 1) && !bad;
      mac_rx_bad_frame  = (w == n_words - 1) && bad;
    end
    @(posedge mac_clk);
    #1;
    mac_rx_data       = '0;
    mac_rx_data_valid = '0;
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;
  endtask

  task automatic wait_for_words(input int n, input int idx);
    int cycles;
    cycles = 0;
    while (got_data.size() < n) begin
      @(posedge mac_clk);
      cycles = cycles + 1;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("timeout: frame %0d delivered only %0d of %0d words",
                            idx, got_data.size(), n));
      end
    end
  endtask

  task automatic wait_for_last(input int idx);
    int cycles;
    cycles = 0;
    while (got_last.size() == 0 || got_last[got_last.size() - 1] !== 1'b1) begin
      @(posedge mac_clk);
      cycles = cycles + 1;
      if (cycles > WAIT_LIMIT) begin
        abort_run($sformatf("timeout: frame %0d never delivered a last word", idx));
      end
    end
  endtask

  task automatic run_frame(input int idx);
    entry_t e;
    int     n;
    string  tag;
    e = table_q[idx];
    build_frame(e, idx);
    got_data.delete();
    got_last.delete();
    got_bad.delete();
    got_over.delete();
    got_ip.delete();
    got_port.delete();
    @(negedge mac_clk);
    hold_ready = e.stall;
    @(posedge mac_clk);
    #1;
    local_enable = e.enable;
    send_frame(e.bad);
    if (e.stall) begin
      // let the cut frame settle in the FIFO before draining
      repeat (8) @(posedge mac_clk);
      @(negedge mac_clk);
      hold_ready = 1'b0;
      wait_for_last(idx);
    end else if (e.accept) begin
      wait_for_words(e.pay_words, idx);
    end
    repeat (QUIET) @(posedge mac_clk);
    @(negedge mac_clk);
    check_flags(rx_valid, 1'b0, $sformatf("frame %0d rx_valid when drained", idx));
    if (e.stall) begin
      n = got_data.size();
      if (n >= e.pay_words) begin
        abort_run($sformatf("FAILED at %0t: frame %0d gave %0d words, expected a cut prefix",
                            $time, idx, n));
      end
    end else begin
      n = e.accept ? e.pay_words : 0;
      check_count(got_data.size(), n, $sformatf("frame %0d word count", idx));
    end
    for (int k = 0; k < n; k++) begin
      tag = $sformatf("frame %0d word %0d", idx, k);
      check_word(got_data[k], expected_word(k), {tag, " data"});
      check_flags(got_last[k], k == n - 1, {tag, " rx_last"});
      check_flags(got_bad[k], e.bad && (k == n - 1), {tag, " rx_bad"});
      check_flags(got_over[k], e.stall && (k == n - 1), {tag, " rx_overrun"});
      check_source(got_ip[k], got_port[k], {tag, " source"});
    end
  endtask

  always @(negedge mac_clk) begin
    if (!mac_rst && rx_valid && rx_ready) begin
      got_data.push_back(rx_data);
      got_last.push_back(rx_last);
      got_bad.push_back(rx_bad);
      got_over.push_back(rx_overrun);
      got_ip.push_back(rx_source_ip);
      got_port.push_back(rx_source_port);
    end
  end

  // back-pressure pattern, own generator so the payload bytes stay fixed
  initial begin
    logic [31:0] ready_state;
    ready_state = lcg_next(SEED);
    rx_ready    = 1'b0;
    forever begin
      @(posedge mac_clk);
      #1;
      ready_state = lcg_next(ready_state);
      rx_ready    = !hold_ready && (ready_state[22] || ready_state[27]);
    end
  end

  initial begin
    lcg_state         = SEED;
    mac_rst           = 1'b1;
    local_enable      = 1'b0;
    local_mac         = LOCAL_MAC;
    local_ip          = LOCAL_IP;
    local_port        = LOCAL_PORT;
    local_mc_ip       = MC_IP;
    local_mc_mask     = MC_MASK;
    mac_rx_data       = '0;
    mac_rx_data_valid = '0;
    mac_rx_good_frame = 1'b0;
    mac_rx_bad_frame  = 1'b0;

    // dst_mac, ethertype, ver_ihl, proto, dst_ip, dst_port,
    // pay_words, bad, enable, accept, stall
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h11, LOCAL_IP, LOCAL_PORT,
                               4, 1'b0, 1'b1, 1'b1, 1'b0});
    table_q.push_back(entry_t'{48'h02_11_22_33_44_66, 16'h0800, 8'h45, 8'h11, LOCAL_IP,
                               LOCAL_PORT, 3, 1'b0, 1'b1, 1'b0, 1'b0});
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h86DD, 8'h45, 8'h11, LOCAL_IP, LOCAL_PORT,
                               3, 1'b0, 1'b1, 1'b0, 1'b0});
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h46, 8'h11, LOCAL_IP, LOCAL_PORT,
                               3, 1'b0, 1'b1, 1'b0, 1'b0});
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h06, LOCAL_IP, LOCAL_PORT,
                               3, 1'b0, 1'b1, 1'b0, 1'b0});
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h11, LOCAL_IP, 16'd5001,
                               3, 1'b0, 1'b1, 1'b0, 1'b0});
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h11, 32'h0A_00_00_63,
                               LOCAL_PORT, 3, 1'b0, 1'b1, 1'b0, 1'b0});
    // shortest frame that still carries payload
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h11, LOCAL_IP, LOCAL_PORT,
                               1, 1'b0, 1'b1, 1'b1, 1'b0});
    table_q.push_back(entry_t'{MAC_BROADCAST, 16'h0800, 8'h45, 8'h11, LOCAL_IP, LOCAL_PORT,
                               5, 1'b0, 1'b1, 1'b1, 1'b0});
    table_q.push_back(entry_t'{MC_MAC, 16'h0800, 8'h45, 8'h11, 32'hEF_01_02_07, LOCAL_PORT,
                               6, 1'b0, 1'b1, 1'b1, 1'b0});
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h11, LOCAL_IP, LOCAL_PORT,
                               4, 1'b1, 1'b1, 1'b1, 1'b0});
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h11, LOCAL_IP, LOCAL_PORT,
                               4, 1'b0, 1'b0, 1'b0, 1'b0});
    // longer than the data FIFO with the reader stalled
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h11, LOCAL_IP, LOCAL_PORT,
                               80, 1'b0, 1'b1, 1'b1, 1'b1});
    table_q.push_back(entry_t'{LOCAL_MAC, 16'h0800, 8'h45, 8'h11, LOCAL_IP, LOCAL_PORT,
                               7, 1'b0, 1'b1, 1'b1, 1'b0});

    repeat (8) @(posedge mac_clk);
    #1;
    mac_rst = 1'b0;
    repeat (4) @(posedge mac_clk);
    for (int i = 0; i < table_q.size(); i++) begin
      run_frame(i);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- verilog/rx_frame_writer.sv
`timescale 1ns/1ps

module rx_frame_writer (
  input  logic                  mac_clk,
  input  logic                  mac_rst,
  input  logic                  pay_valid,
  input  logic                  pay_last,
  input  logic                  pay_bad,
  input  udp_rx_pkg::word_t     payload_word,
  input  udp_rx_pkg::ip_addr_t  src_ip,
  input  udp_rx_pkg::udp_port_t src_port,
  input  logic                  data_afull,
  input  logic                  ctrl_afull,
  output logic                  data_wr_en,
  output udp_rx_pkg::word_t     data_wr_word,
  output logic                  data_wr_last,
  output logic                  data_wr_bad,
  output logic                  data_wr_over,
  output logic                  ctrl_wr_en,
  output udp_rx_pkg::ip_addr_t  ctrl_wr_ip,
  output udp_rx_pkg::udp_port_t ctrl_wr_port
);
  import udp_rx_pkg::*;

  wr_state_t state;
  logic      first_word;
  logic      afull;

  // either FIFO close to full ends the frame here
  assign afull = data_afull || ctrl_afull;

  assign data_wr_en   = pay_valid && (state == WR_RUN);
  assign data_wr_word = payload_word;
  assign data_wr_last = pay_last || afull;
  assign data_wr_bad  = pay_bad;
  assign data_wr_over = afull;

  // one control entry per frame, written with its first word
  assign ctrl_wr_en   = data_wr_en && first_word;
  assign ctrl_wr_ip   = src_ip;
  assign ctrl_wr_port = src_port;

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state      <= WR_RUN;
      first_word <= 1'b1;
    end else begin
      case (state)
        WR_RUN: begin
          if (pay_valid) begin
            // a cut frame also counts as finished
            first_word <= pay_last || afull;
            if (afull && !pay_last) begin
              state <= WR_DROP;
            end
          end
        end
        WR_DROP: begin
          // wait out the rest of the cut frame
          if (pay_valid && pay_last) begin
            state <= WR_RUN;
          end
        end
        default: begin
          state <= WR_RUN;
        end
      endcase
    end
  end

  // a word cut mid-frame is followed by dropped words, never a write
  a_no_write_in_drop: assert property (@(posedge mac_clk) disable iff (mac_rst)
    data_wr_en && data_wr_over && !pay_last |=> !data_wr_en && !ctrl_wr_en)
    else $error("FIFO write while dropping");

endmodule

//--- verilog/rx_header_filter.sv
`timescale 1ns/1ps

module rx_header_filter (
  input  logic                  mac_clk,
  input  logic                  mac_rst,
  input  udp_rx_pkg::word_t     cur_word,
  input  udp_rx_pkg::word_t     prev_word,
  input  logic                  word_valid,
  input  logic                  frame_start,
  input  logic                  frame_end,
  input  logic                  end_bad,
  input  logic                  local_enable,
  input  udp_rx_pkg::mac_addr_t local_mac,
  input  udp_rx_pkg::ip_addr_t  local_ip,
  input  udp_rx_pkg::udp_port_t local_port,
  input  udp_rx_pkg::ip_addr_t  local_mc_ip,
  input  udp_rx_pkg::ip_addr_t  local_mc_mask,
  output logic                  pay_valid,
  output logic                  pay_last,
  output logic                  pay_bad,
  output udp_rx_pkg::ip_addr_t  src_ip,
  output udp_rx_pkg::udp_port_t src_port
);
  import udp_rx_pkg::*;

  rx_state_t state;
  logic      accept;
  // frame end seen one word ago, lines up with prev_word
  logic      last_q;
  logic      bad_q;

  mac_addr_t dst_mac;
  ip_addr_t  dst_ip;
  udp_port_t dst_port;
  logic      mac_ok;
  logic      ipv4_ok;
  logic      udp_ok;
  logic      ip_ok;

  // fields are rebuilt with the first byte on the wire on top
  // word 0 sits in prev_word during hdr1
  assign dst_mac  = {prev_word[7:0], prev_word[15:8], prev_word[23:16],
                     prev_word[31:24], prev_word[39:32], prev_word[47:40]};
  // destination IP is bytes 30..33, split over words 3 and 4
  assign dst_ip   = {prev_word[55:48], prev_word[63:56], cur_word[7:0], cur_word[15:8]};
  assign dst_port = {cur_word[39:32], cur_word[47:40]};

  assign mac_ok  = (dst_mac == local_mac) || (dst_mac == MAC_BROADCAST) ||
                   (dst_mac[47:24] == MAC_MCAST_PREFIX);
  assign ipv4_ok = ({cur_word[39:32], cur_word[47:40]} == ETHERTYPE_IPV4) &&
                   (cur_word[55:48] == IPV4_VER_IHL);
  assign udp_ok  = cur_word[63:56] == IP_PROTO_UDP;
  // exact unicast match, or a subscribed multicast group
  assign ip_ok   = (dst_ip == local_ip) ||
                   ((dst_ip & local_mc_mask) == (local_mc_ip & local_mc_mask));

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      state  <= RX_IDLE;
      accept <= 1'b0;
      last_q <= 1'b0;
      bad_q  <= 1'b0;
    end else begin
      last_q <= frame_end;
      bad_q  <= end_bad;
      if (word_valid && frame_start) begin
        // a new frame always restarts the walk
        accept <= local_enable;
        state  <= frame_end ? RX_IDLE : RX_HDR1;
      end else begin
        case (state)
          RX_IDLE: begin
            state <= RX_IDLE;
          end
          RX_HDR1: begin
            if (!mac_ok || !ipv4_ok) begin
              accept <= 1'b0;
            end
            state <= frame_end ? RX_IDLE : RX_HDR2;
          end
          RX_HDR2: begin
            if (!udp_ok) begin
              accept <= 1'b0;
            end
            state <= frame_end ? RX_IDLE : RX_HDR3;
          end
          RX_HDR3: begin
            state <= frame_end ? RX_IDLE : RX_HDR4;
          end
          RX_HDR4: begin
            if (!ip_ok || dst_port != local_port) begin
              accept <= 1'b0;
            end
            state <= frame_end ? RX_IDLE : RX_HDR5;
          end
          RX_HDR5: begin
            // word 5 is the first payload source, even as the last word
            state <= RX_PAYLOAD;
          end
          RX_PAYLOAD: begin
            if (last_q) begin
              state <= RX_IDLE;
            end
          end
          default: begin
            state <= RX_IDLE;
          end
        endcase
      end
    end
  end

  // source address and port for the control FIFO
  always_ff @(posedge mac_clk) begin
    if (state == RX_HDR3) begin
      src_ip <= {cur_word[23:16], cur_word[31:24], cur_word[39:32], cur_word[47:40]};
    end
    if (state == RX_HDR4) begin
      src_port <= {cur_word[23:16], cur_word[31:24]};
    end
  end

  assign pay_valid = accept && (state == RX_PAYLOAD);
  assign pay_last  = last_q;
  assign pay_bad   = bad_q;

  // a header state always has its word present in cur_word
  a_state_legal: assert property (@(posedge mac_clk) disable iff (mac_rst)
    state inside {RX_HDR1, RX_HDR2, RX_HDR3, RX_HDR4, RX_HDR5} |-> word_valid)
    else $error("header state without an input word");

endmodule

//--- verilog/rx_input_align.sv
`timescale 1ns/1ps

module rx_input_align (
  input  logic               mac_clk,
  input  logic               mac_rst,
  input  udp_rx_pkg::word_t  mac_rx_data,
  input  udp_rx_pkg::lanes_t mac_rx_data_valid,
  input  logic               mac_rx_good_frame,
  input  logic               mac_rx_bad_frame,
  output udp_rx_pkg::word_t  cur_word,
  output udp_rx_pkg::word_t  prev_word,
  output logic               word_valid,
  output logic               frame_start,
  output logic               frame_end,
  output logic               end_bad,
  output udp_rx_pkg::word_t  payload_word
);

  logic in_full;
  logic in_end;
  // previous input word was inside a frame and not its last
  logic in_frame;
  logic prev_end;

  assign in_full = mac_rx_data_valid == '1;
  assign in_end  = mac_rx_good_frame || mac_rx_bad_frame;

  // idle words read as zero so the tail of the last payload word is clean
  always_ff @(posedge mac_clk) begin
    cur_word  <= in_full ? mac_rx_data : '0;
    prev_word <= cur_word;
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      word_valid  <= 1'b0;
      frame_start <= 1'b0;
      frame_end   <= 1'b0;
      end_bad     <= 1'b0;
      in_frame    <= 1'b0;
      prev_end    <= 1'b0;
    end else begin
      word_valid  <= in_full;
      frame_start <= in_full && !in_frame;
      frame_end   <= in_full && in_end;
      end_bad     <= in_full && mac_rx_bad_frame;
      in_frame    <= in_full && !in_end;
      prev_end    <= frame_end;
    end
  end

  // payload starts at frame byte 42, i.e. byte 2 of a word
  // bytes from the word after the frame's last are masked off
  assign payload_word = {prev_word[23:16], prev_word[31:24], prev_word[39:32],
                         prev_word[47:40], prev_word[55:48], prev_word[63:56],
                         prev_end ? 16'h0000 : {cur_word[7:0], cur_word[15:8]}};

  a_end_pulses_exclusive: assert property (@(posedge mac_clk) disable iff (mac_rst)
    !(mac_rx_good_frame && mac_rx_bad_frame))
    else $error("good and bad frame pulses together");

endmodule

//--- verilog/sync_fifo.sv
`timescale 1ns/1ps

module sync_fifo #(
  parameter int WIDTH        = 8,
  parameter int DEPTH_LOG2   = 4,
  parameter int AFULL_MARGIN = 2
) (
  input  logic             mac_clk,
  input  logic             mac_rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] wr_data,
  input  logic             rd_en,
  output logic [WIDTH-1:0] rd_data,
  output logic             empty,
  output logic             almost_full
);

  localparam int DEPTH = 1 << DEPTH_LOG2;
  localparam logic [DEPTH_LOG2:0] FULL_COUNT  = (DEPTH_LOG2 + 1)'(DEPTH);
  localparam logic [DEPTH_LOG2:0] AFULL_LEVEL = (DEPTH_LOG2 + 1)'(DEPTH - AFULL_MARGIN);

  logic [WIDTH-1:0]      mem [DEPTH];
  logic [DEPTH_LOG2-1:0] wr_ptr;
  logic [DEPTH_LOG2-1:0] rd_ptr;
  logic [DEPTH_LOG2:0]   count;
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = wr_en && (count != FULL_COUNT);
  assign do_rd = rd_en && !empty;

  always_ff @(posedge mac_clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  always_ff @(posedge mac_clk) begin
    if (mac_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // first word falls through, visible the cycle after its write
  assign rd_data     = mem[rd_ptr];
  assign empty       = count == '0;
  assign almost_full = count >= AFULL_LEVEL;

  a_no_write_full: assert property (@(posedge mac_clk) disable iff (mac_rst)
    wr_en |-> count != FULL_COUNT)
    else $error("write to full FIFO");

  a_no_read_empty: assert property (@(posedge mac_clk) disable iff (mac_rst)
    rd_en |-> !empty)
    else $error("read from empty FIFO");

endmodule

//--- verilog/udp_rx_pkg.sv
package udp_rx_pkg;

  // one MAC word, byte 0 in bits 7:0
  typedef logic [63:0] word_t;
  typedef logic [7:0]  lanes_t;

  typedef logic [47:0] mac_addr_t;
  typedef logic [31:0] ip_addr_t;
  typedef logic [15:0] udp_port_t;

  // header walk, each hdr state names the word held in cur_word
  typedef enum logic [2:0] {
    RX_IDLE,
    RX_HDR1,
    RX_HDR2,
    RX_HDR3,
    RX_HDR4,
    RX_HDR5,
    RX_PAYLOAD
  } rx_state_t;

  // writer: drop discards the tail of an overrun frame
  typedef enum logic {
    WR_RUN,
    WR_DROP
  } wr_state_t;

  localparam logic [15:0] ETHERTYPE_IPV4 = 16'h0800;
  localparam logic [7:0]  IPV4_VER_IHL   = 8'h45;
  localparam logic [7:0]  IP_PROTO_UDP   = 8'h11;

  // IPv4 multicast MACs start with 01:00:5E
  localparam logic [23:0] MAC_MCAST_PREFIX = 24'h01005E;
  localparam mac_addr_t   MAC_BROADCAST    = '1;

  // data entry is {overrun, bad, last, word}
  localparam int DATA_FIFO_W = 64 + 3;
  // control entry is {port, ip}
  localparam int CTRL_FIFO_W = 48;

endpackage

//--- verilog/udp_rx_top.sv
`timescale 1ns/1ps

module udp_rx_top #(
  parameter int DATA_DEPTH_LOG2 = 6,
  parameter int CTRL_DEPTH_LOG2 = 3,
  parameter int AFULL_MARGIN    = 4
) (
  input  logic                  mac_clk,
  input  logic                  mac_rst,
  input  logic                  local_enable,
  input  udp_rx_pkg::mac_addr_t local_mac,
  input  udp_rx_pkg::ip_addr_t  local_ip,
  input  udp_rx_pkg::udp_port_t local_port,
  input  udp_rx_pkg::ip_addr_t  local_mc_ip,
  input  udp_rx_pkg::ip_addr_t  local_mc_mask,
  input  udp_rx_pkg::word_t     mac_rx_data,
  input  udp_rx_pkg::lanes_t    mac_rx_data_valid,
  input  logic                  mac_rx_good_frame,
  input  logic                  mac_rx_bad_frame,
  output logic                  rx_valid,
  output udp_rx_pkg::word_t     rx_data,
  output logic                  rx_last,
  output logic                  rx_bad,
  output logic                  rx_overrun,
  output udp_rx_pkg::ip_addr_t  rx_source_ip,
  output udp_rx_pkg::udp_port_t rx_source_port,
  input  logic                  rx_ready
);
  import udp_rx_pkg::*;

  word_t     cur_word;
  word_t     prev_word;
  word_t     payload_word;
  logic      word_valid;
  logic      frame_start;
  logic      frame_end;
  logic      end_bad;

  logic      pay_valid;
  logic      pay_last;
  logic      pay_bad;
  ip_addr_t  src_ip;
  udp_port_t src_port;

  logic      data_wr_en;
  word_t     data_wr_word;
  logic      data_wr_last;
  logic      data_wr_bad;
  logic      data_wr_over;
  logic      ctrl_wr_en;
  ip_addr_t  ctrl_wr_ip;
  udp_port_t ctrl_wr_port;

  logic                   data_afull;
  logic                   ctrl_afull;
  logic                   data_empty;
  logic                   ctrl_empty;
  logic                   data_rd_en;
  logic                   ctrl_rd_en;
  logic [DATA_FIFO_W-1:0] data_rd;
  logic [CTRL_FIFO_W-1:0] ctrl_rd;

  rx_input_align i_rx_input_align (.*);

  rx_header_filter i_rx_header_filter (.*);

  rx_frame_writer i_rx_frame_writer (.*);

  sync_fifo #(
    .WIDTH        (DATA_FIFO_W),
    .DEPTH_LOG2   (DATA_DEPTH_LOG2),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) i_data_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (data_wr_en),
    .wr_data     ({data_wr_over, data_wr_bad, data_wr_last, data_wr_word}),
    .rd_en       (data_rd_en),
    .rd_data     (data_rd),
    .empty       (data_empty),
    .almost_full (data_afull)
  );

  sync_fifo #(
    .WIDTH        (CTRL_FIFO_W),
    .DEPTH_LOG2   (CTRL_DEPTH_LOG2),
    .AFULL_MARGIN (AFULL_MARGIN)
  ) i_ctrl_fifo (
    .mac_clk     (mac_clk),
    .mac_rst     (mac_rst),
    .wr_en       (ctrl_wr_en),
    .wr_data     ({ctrl_wr_port, ctrl_wr_ip}),
    .rd_en       (ctrl_rd_en),
    .rd_data     (ctrl_rd),
    .empty       (ctrl_empty),
    .almost_full (ctrl_afull)
  );

  // the control entry goes in with the first data word, so both heads line up
  assign rx_valid       = !data_empty && !ctrl_empty;
  assign data_rd_en     = rx_valid && rx_ready;
  // one control entry per frame, released by its last word
  assign ctrl_rd_en     = data_rd_en && rx_last;

  assign rx_data        = data_rd[63:0];
  assign rx_last        = data_rd[64];
  assign rx_bad         = data_rd[65];
  assign rx_overrun     = data_rd[66];
  assign rx_source_ip   = ctrl_rd[31:0];
  assign rx_source_port = ctrl_rd[47:32];

endmodule
